//--- mpf_pkg.sv
// Definitions shared by the memory shim RTL and its testbench
package mpf_pkg;

    // Request opcode carried in the top bit of each request FIFO word
    typedef enum logic [0:0]
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    }
    t_mem_op;

    // Arbiter state, tracking whether the previous cycle issued a request
    typedef enum logic [0:0]
    {
        ARB_IDLE  = 1'b0,
        ARB_ISSUE = 1'b1
    }
    t_arb_state;

    // Default address width, giving a 256 word shared memory
    localparam int DEF_ADDR_BITS = 8;

    // Default width of one memory word
    localparam int DEF_DATA_BITS = 32;

    // Default number of requester channels
    localparam int DEF_N_CHANNELS = 2;

    // Default depth of each channel's request FIFO
    localparam int DEF_REQ_ENTRIES = 8;

    // Default depth of each channel's response FIFO
    // Four entries leave room for the one read that may be in flight
    // when the arbiter sees almost-full
    localparam int DEF_RSP_ENTRIES = 4;

endpackage

//--- mpf_fifo_lutram.sv
`timescale 1ns/1ns

// FIFO built on distributed RAM with registered level flags
// The head entry is visible on first without a dequeue
module mpf_fifo_lutram
#(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES = 8,
    parameter int THRESHOLD = 1
)
(
    input  logic                   clk,
    input  logic                   reset_n,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,
    output logic                   not_full,
    output logic                   almost_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic                   deq_en,
    output logic                   not_empty
);

    // Index width covers a single entry FIFO as well
    localparam int IDX_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    // The count must represent both zero and N_ENTRIES
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    logic [N_DATA_BITS-1:0] data [0:N_ENTRIES-1];

    logic [IDX_BITS-1:0] wr_idx;
    logic [IDX_BITS-1:0] rd_idx;

    logic [CNT_BITS-1:0] valid_cnt;
    logic [CNT_BITS-1:0] valid_cnt_next;

    // Head of the queue, read asynchronously from the LUT storage
    assign first = data[rd_idx];

    // Storage is written at the tail and holds no reset
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            data[wr_idx] <= enq_data;
        end
    end

    // Both indices wrap at N_ENTRIES so any depth works
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_idx <= '0;
            rd_idx <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_idx <= (wr_idx == IDX_BITS'(N_ENTRIES - 1)) ? '0 : wr_idx + 1'b1;
            end
            if (deq_en)
            begin
                rd_idx <= (rd_idx == IDX_BITS'(N_ENTRIES - 1)) ? '0 : rd_idx + 1'b1;
            end
        end
    end

    // An enqueue and a dequeue in the same cycle cancel out
    always_comb
    begin
        valid_cnt_next = valid_cnt;
        if (enq_en && !deq_en)
        begin
            valid_cnt_next = valid_cnt + 1'b1;
        end
        else if (deq_en && !enq_en)
        begin
            valid_cnt_next = valid_cnt - 1'b1;
        end
    end

    // Flags are computed from the next count so they line up with it
    // almost_full means THRESHOLD or fewer slots remain free
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            valid_cnt <= '0;
            not_full <= 1'b1;
            almost_full <= 1'b0;
            not_empty <= 1'b0;
        end
        else
        begin
            valid_cnt <= valid_cnt_next;
            not_full <= (valid_cnt_next != CNT_BITS'(N_ENTRIES));
            almost_full <= (valid_cnt_next >= CNT_BITS'(N_ENTRIES - THRESHOLD));
            not_empty <= (valid_cnt_next != '0);
        end
    end

    // The producer must honor not_full from the previous edge
    a_no_overflow : assert property (@(posedge clk) disable iff (!reset_n)
        enq_en |-> not_full)
        else $error("mpf_fifo_lutram: enqueue to a full FIFO");

    // The consumer must honor not_empty from the previous edge
    a_no_underflow : assert property (@(posedge clk) disable iff (!reset_n)
        deq_en |-> not_empty)
        else $error("mpf_fifo_lutram: dequeue from an empty FIFO");

endmodule

//--- mpf_rr_arbiter.sv
`timescale 1ns/1ns

// Round-robin arbiter granting one channel's head request per cycle
// The grant, the dequeue strobe and the memory command are all combinational
module mpf_rr_arbiter
#(
    parameter int N_CHANNELS = 2,
    parameter int ADDR_BITS = 8,
    parameter int DATA_BITS = 32
)
(
    input  logic                                  clk,
    input  logic                                  reset_n,

    input  logic [N_CHANNELS-1:0]                 head_valid,
    input  mpf_pkg::t_mem_op [N_CHANNELS-1:0]     head_op,
    input  logic [N_CHANNELS-1:0][ADDR_BITS-1:0]  head_addr,
    input  logic [N_CHANNELS-1:0][DATA_BITS-1:0]  head_wdata,
    input  logic [N_CHANNELS-1:0]                 rsp_almost_full,

    output logic [N_CHANNELS-1:0]                 deq_en,
    output logic                                  mem_en,
    output mpf_pkg::t_mem_op                      mem_op,
    output logic [ADDR_BITS-1:0]                  mem_addr,
    output logic [DATA_BITS-1:0]                  mem_wdata,
    output logic [((N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1)-1:0] mem_chan
);

    localparam int CHAN_BITS = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    logic [N_CHANNELS-1:0] eligible;
    logic                  grant_valid;
    logic [CHAN_BITS-1:0]  grant_chan;
    logic [CHAN_BITS-1:0]  last_grant;

    mpf_pkg::t_arb_state   arb_state;

    // Writes never return data, so only reads wait on response space
    always_comb
    begin
        for (int i = 0; i < N_CHANNELS; i++)
        begin
            eligible[i] = head_valid[i] &&
                          ((head_op[i] == mpf_pkg::OP_WRITE) || !rsp_almost_full[i]);
        end
    end

    // Search starts one past the last winner and wraps around once
    // The last winner itself is checked last
    always_comb
    begin
        int cand;
        grant_valid = 1'b0;
        grant_chan = last_grant;
        for (int k = 1; k <= N_CHANNELS; k++)
        begin
            cand = int'(last_grant) + k;
            if (cand >= N_CHANNELS)
            begin
                cand = cand - N_CHANNELS;
            end
            if (!grant_valid && eligible[cand])
            begin
                grant_valid = 1'b1;
                grant_chan = CHAN_BITS'(cand);
            end
        end
    end

    // The winner's head is dequeued at the same edge the memory acts on it
    always_comb
    begin
        for (int i = 0; i < N_CHANNELS; i++)
        begin
            deq_en[i] = grant_valid && (grant_chan == CHAN_BITS'(i));
        end
    end

    assign mem_en = grant_valid;
    assign mem_op = head_op[grant_chan];
    assign mem_addr = head_addr[grant_chan];
    assign mem_wdata = head_wdata[grant_chan];
    assign mem_chan = grant_chan;

    // Channel 0 wins first after reset since the pointer starts at the top
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            last_grant <= CHAN_BITS'(N_CHANNELS - 1);
            arb_state <= mpf_pkg::ARB_IDLE;
        end
        else
        begin
            if (grant_valid)
            begin
                last_grant <= grant_chan;
            end
            arb_state <= grant_valid ? mpf_pkg::ARB_ISSUE : mpf_pkg::ARB_IDLE;
        end
    end

    // At most one request FIFO is popped per cycle
    a_deq_onehot : assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(deq_en))
        else $error("mpf_rr_arbiter: more than one channel dequeued");

    // The channel popped in the previous cycle yields to any other eligible channel
    a_rr_rotates : assert property (@(posedge clk) disable iff (!reset_n)
        ((arb_state == mpf_pkg::ARB_ISSUE) && ($countones(eligible) > 1))
        |-> ((deq_en & $past(deq_en)) == '0))
        else $error("mpf_rr_arbiter: channel granted twice while others waited");

endmodule

//--- mpf_shared_mem.sv
`timescale 1ns/1ns

// Single-port memory shared by all channels
// Reads return one cycle after the grant, tagged with the requesting channel
module mpf_shared_mem
#(
    parameter int N_CHANNELS = 2,
    parameter int ADDR_BITS = 8,
    parameter int DATA_BITS = 32
)
(
    input  logic                 clk,
    input  logic                 reset_n,

    input  logic                 mem_en,
    input  mpf_pkg::t_mem_op     mem_op,
    input  logic [ADDR_BITS-1:0] mem_addr,
    input  logic [DATA_BITS-1:0] mem_wdata,
    input  logic [((N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1)-1:0] mem_chan,

    output logic                 rd_valid,
    output logic [((N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1)-1:0] rd_chan,
    output logic [DATA_BITS-1:0] rd_data
);

    localparam int N_WORDS = 1 << ADDR_BITS;

    logic [DATA_BITS-1:0] mem [0:N_WORDS-1];

    logic is_read;
    logic is_write;

    assign is_read = mem_en && (mem_op == mpf_pkg::OP_READ);
    assign is_write = mem_en && (mem_op == mpf_pkg::OP_WRITE);

    // Array contents and the returned word are data only
    // A write lands at its grant edge, so any later read sees it
    always_ff @(posedge clk)
    begin
        if (is_write)
        begin
            mem[mem_addr] <= mem_wdata;
        end
        if (is_read)
        begin
            rd_data <= mem[mem_addr];
            rd_chan <= mem_chan;
        end
    end

    // Valid pulses for exactly one cycle per granted read
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= is_read;
        end
    end

endmodule

//--- mpf_rsp_router.sv
`timescale 1ns/1ns

// Steers returning read data into the response FIFO of its channel
// The FIFOs' almost-full levels go back to the arbiter as read back-pressure
module mpf_rsp_router
#(
    parameter int N_CHANNELS = 2,
    parameter int DATA_BITS = 32,
    parameter int RSP_ENTRIES = 4
)
(
    input  logic                                 clk,
    input  logic                                 reset_n,

    input  logic                                 rd_valid,
    input  logic [((N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1)-1:0] rd_chan,
    input  logic [DATA_BITS-1:0]                 rd_data,

    input  logic [N_CHANNELS-1:0]                rsp_deq,
    output logic [N_CHANNELS-1:0][DATA_BITS-1:0] rsp_data,
    output logic [N_CHANNELS-1:0]                rsp_not_empty,
    output logic [N_CHANNELS-1:0]                rsp_almost_full
);

    localparam int CHAN_BITS = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    logic [N_CHANNELS-1:0] rsp_enq;
    logic [N_CHANNELS-1:0] rsp_not_full;

    // The channel tag selects exactly one FIFO to receive the word
    always_comb
    begin
        for (int i = 0; i < N_CHANNELS; i++)
        begin
            rsp_enq[i] = rd_valid && (rd_chan == CHAN_BITS'(i));
        end
    end

    // Threshold of two covers the read already between grant and enqueue
    // when almost_full is first seen by the arbiter
    for (genvar i = 0; i < N_CHANNELS; i++)
    begin : g_rsp_fifo
        mpf_fifo_lutram
        #(
            .N_DATA_BITS (DATA_BITS),
            .N_ENTRIES   (RSP_ENTRIES),
            .THRESHOLD   (2)
        )
        rsp_fifo
        (
            .clk         (clk),
            .reset_n     (reset_n),
            .enq_data    (rd_data),
            .enq_en      (rsp_enq[i]),
            .not_full    (rsp_not_full[i]),
            .almost_full (rsp_almost_full[i]),
            .first       (rsp_data[i]),
            .deq_en      (rsp_deq[i]),
            .not_empty   (rsp_not_empty[i])
        );
    end

    // The arbiter's read throttling must keep room for every returning word
    // and the tag must name a real channel
    a_rsp_room : assert property (@(posedge clk) disable iff (!reset_n)
        rd_valid |-> ((int'(rd_chan) < N_CHANNELS) && rsp_not_full[rd_chan]))
        else $error("mpf_rsp_router: read data returned to a full or missing FIFO");

endmodule

//--- mpf_mem_shim_top.sv
`timescale 1ns/1ns

// Shared memory front end
// Each channel queues requests in its own FIFO, a round-robin arbiter picks
// one head per cycle for the memory, and read data comes back through a
// per-channel response FIFO
module mpf_mem_shim_top
#(
    parameter int N_CHANNELS = mpf_pkg::DEF_N_CHANNELS,
    parameter int ADDR_BITS = mpf_pkg::DEF_ADDR_BITS,
    parameter int DATA_BITS = mpf_pkg::DEF_DATA_BITS,
    parameter int REQ_ENTRIES = mpf_pkg::DEF_REQ_ENTRIES,
    parameter int RSP_ENTRIES = mpf_pkg::DEF_RSP_ENTRIES
)
(
    input  logic                                 clk,
    input  logic                                 reset_n,

    // Request side, one lane per channel
    input  logic [N_CHANNELS-1:0]                req_en,
    input  mpf_pkg::t_mem_op [N_CHANNELS-1:0]    req_op,
    input  logic [N_CHANNELS-1:0][ADDR_BITS-1:0] req_addr,
    input  logic [N_CHANNELS-1:0][DATA_BITS-1:0] req_wdata,
    output logic [N_CHANNELS-1:0]                req_not_full,
    output logic [N_CHANNELS-1:0]                req_almost_full,

    // Response side, one lane per channel
    input  logic [N_CHANNELS-1:0]                rsp_deq,
    output logic [N_CHANNELS-1:0][DATA_BITS-1:0] rsp_data,
    output logic [N_CHANNELS-1:0]                rsp_not_empty
);

    localparam int CHAN_BITS = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;
    // Request word is opcode, then address, then write data
    localparam int REQ_BITS = 1 + ADDR_BITS + DATA_BITS;

    logic [N_CHANNELS-1:0][REQ_BITS-1:0]  req_first;
    logic [N_CHANNELS-1:0]                head_valid;
    mpf_pkg::t_mem_op [N_CHANNELS-1:0]    head_op;
    logic [N_CHANNELS-1:0][ADDR_BITS-1:0] head_addr;
    logic [N_CHANNELS-1:0][DATA_BITS-1:0] head_wdata;
    logic [N_CHANNELS-1:0]                req_deq;
    logic [N_CHANNELS-1:0]                rsp_almost_full;

    logic                                 mem_en;
    mpf_pkg::t_mem_op                     mem_op;
    logic [ADDR_BITS-1:0]                 mem_addr;
    logic [DATA_BITS-1:0]                 mem_wdata;
    logic [CHAN_BITS-1:0]                 mem_chan;

    logic                                 rd_valid;
    logic [CHAN_BITS-1:0]                 rd_chan;
    logic [DATA_BITS-1:0]                 rd_data;

    // Request FIFOs flag almost-full with a single slot left
    for (genvar i = 0; i < N_CHANNELS; i++)
    begin : g_req_fifo
        mpf_fifo_lutram
        #(
            .N_DATA_BITS (REQ_BITS),
            .N_ENTRIES   (REQ_ENTRIES),
            .THRESHOLD   (1)
        )
        req_fifo
        (
            .clk         (clk),
            .reset_n     (reset_n),
            .enq_data    ({req_op[i], req_addr[i], req_wdata[i]}),
            .enq_en      (req_en[i]),
            .not_full    (req_not_full[i]),
            .almost_full (req_almost_full[i]),
            .first       (req_first[i]),
            .deq_en      (req_deq[i]),
            .not_empty   (head_valid[i])
        );

        // Split the head word back into its fields for the arbiter
        assign head_op[i] = mpf_pkg::t_mem_op'(req_first[i][REQ_BITS-1]);
        assign head_addr[i] = req_first[i][DATA_BITS +: ADDR_BITS];
        assign head_wdata[i] = req_first[i][DATA_BITS-1:0];
    end

    mpf_rr_arbiter
    #(
        .N_CHANNELS (N_CHANNELS),
        .ADDR_BITS  (ADDR_BITS),
        .DATA_BITS  (DATA_BITS)
    )
    arbiter
    (
        .clk             (clk),
        .reset_n         (reset_n),
        .head_valid      (head_valid),
        .head_op         (head_op),
        .head_addr       (head_addr),
        .head_wdata      (head_wdata),
        .rsp_almost_full (rsp_almost_full),
        .deq_en          (req_deq),
        .mem_en          (mem_en),
        .mem_op          (mem_op),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_chan        (mem_chan)
    );

    mpf_shared_mem
    #(
        .N_CHANNELS (N_CHANNELS),
        .ADDR_BITS  (ADDR_BITS),
        .DATA_BITS  (DATA_BITS)
    )
    memory
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_en    (mem_en),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_chan  (mem_chan),
        .rd_valid  (rd_valid),
        .rd_chan   (rd_chan),
        .rd_data   (rd_data)
    );

    mpf_rsp_router
    #(
        .N_CHANNELS  (N_CHANNELS),
        .DATA_BITS   (DATA_BITS),
        .RSP_ENTRIES (RSP_ENTRIES)
    )
    router
    (
        .clk             (clk),
        .reset_n         (reset_n),
        .rd_valid        (rd_valid),
        .rd_chan         (rd_chan),
        .rd_data         (rd_data),
        .rsp_deq         (rsp_deq),
        .rsp_data        (rsp_data),
        .rsp_not_empty   (rsp_not_empty),
        .rsp_almost_full (rsp_almost_full)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

// Free running testbench clock with a synchronous active-low reset
// Reset covers the first two rising edges and is released on a falling edge
module tb_clock_gen
#(
    parameter int PERIOD = 8
)
(
    output logic clk,
    output logic reset_n
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    initial
    begin
        reset_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

//--- tb_mem_shim.sv
`timescale 1ns/1ns

// Testbench for the shared memory shim with two channels
// A reference memory predicts every read, and each channel keeps its expected
// read data in request order since the shim only orders within a channel
module tb_mem_shim;

    localparam int N_CH = 2;
    localparam int ADDR_BITS = mpf_pkg::DEF_ADDR_BITS;
    localparam int DATA_BITS = mpf_pkg::DEF_DATA_BITS;
    localparam int REQ_ENTRIES = 8;
    localparam int RSP_ENTRIES = 4;
    localparam int N_WORDS = 1 << ADDR_BITS;
    // Each channel owns one half of the memory for its private traffic
    localparam int REGION = N_WORDS / N_CH;
    localparam int WAIT_LIMIT = 400;
    // Longest gap allowed between two responses of a channel that has reads pending
    localparam int STARVE_LIMIT = 64;

    logic clk;
    logic reset_n;

    logic [N_CH-1:0]                req_en;
    mpf_pkg::t_mem_op [N_CH-1:0]    req_op;
    logic [N_CH-1:0][ADDR_BITS-1:0] req_addr;
    logic [N_CH-1:0][DATA_BITS-1:0] req_wdata;
    logic [N_CH-1:0]                req_not_full;
    logic [N_CH-1:0]                req_almost_full;
    logic [N_CH-1:0]                rsp_deq;
    logic [N_CH-1:0][DATA_BITS-1:0] rsp_data;
    logic [N_CH-1:0]                rsp_not_empty;

    // Model state
    logic [DATA_BITS-1:0] ref_mem [0:N_WORDS-1];
    logic [N_WORDS-1:0]   written;
    logic [DATA_BITS-1:0] exp_q [N_CH][$];
    logic [N_CH-1:0]      drain_en;
    logic [ADDR_BITS-1:0] last_addr [N_CH];
    int                   issued [N_CH];
    int                   received [N_CH];
    int                   idle_cycles [N_CH];
    logic [31:0]          seed;
    int                   checks;
    int                   errors;
    int                   timeouts;

    tb_clock_gen clock_gen
    (
        .clk     (clk),
        .reset_n (reset_n)
    );

    mpf_mem_shim_top
    #(
        .N_CHANNELS  (N_CH),
        .ADDR_BITS   (ADDR_BITS),
        .DATA_BITS   (DATA_BITS),
        .REQ_ENTRIES (REQ_ENTRIES),
        .RSP_ENTRIES (RSP_ENTRIES)
    )
    dut0
    (
        .clk             (clk),
        .reset_n         (reset_n),
        .req_en          (req_en),
        .req_op          (req_op),
        .req_addr        (req_addr),
        .req_wdata       (req_wdata),
        .req_not_full    (req_not_full),
        .req_almost_full (req_almost_full),
        .rsp_deq         (rsp_deq),
        .rsp_data        (rsp_data),
        .rsp_not_empty   (rsp_not_empty)
    );

    // Linear congruential generator whose upper bits are the useful ones
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [ADDR_BITS-1:0] region_addr(input int ch, input logic [31:0] r);
        return ADDR_BITS'(ch * REGION + int'(r[23:16]) % REGION);
    endfunction

    // Random word of the channel's region that already holds known data
    function automatic logic [ADDR_BITS-1:0] written_addr(input int ch);
        logic [ADDR_BITS-1:0] a;
        for (int t = 0; t < 16; t++)
        begin
            a = region_addr(ch, next_rand());
            if (written[a])
            begin
                return a;
            end
        end
        return last_addr[ch];
    endfunction

    task automatic check_flag(input string what, input int ch, input logic got, input logic exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERR @%0t: channel %0d %s is %b, expected %b", $time, ch, what, got, exp);
            errors++;
        end
    endtask

    // Pops one response per channel per cycle and compares it with the model
    task automatic collect_responses();
        logic [DATA_BITS-1:0] exp;
        for (int ch = 0; ch < N_CH; ch++)
        begin
            rsp_deq[ch] = 1'b0;
            if (drain_en[ch] && rsp_not_empty[ch] === 1'b1)
            begin
                rsp_deq[ch] = 1'b1;
                received[ch]++;
                idle_cycles[ch] = 0;
                assert (exp_q[ch].size() != 0)
                else
                begin
                    $display("Channel %0d returned a response that no read asked for", ch);
                    errors++;
                end
                if (exp_q[ch].size() != 0)
                begin
                    exp = exp_q[ch].pop_front();
                    checks++;
                    assert (rsp_data[ch] === exp)
                    else
                    begin
                        $display("ERR @%0t: channel %0d read data %h, expected %h",
                                 $time, ch, rsp_data[ch], exp);
                        errors++;
                    end
                end
            end
            else if (drain_en[ch] && exp_q[ch].size() != 0)
            begin
                idle_cycles[ch]++;
                assert (idle_cycles[ch] != STARVE_LIMIT)
                else
                begin
                    $display("Channel %0d got no response for %0d cycles", ch, STARVE_LIMIT);
                    errors++;
                end
            end
            else
            begin
                idle_cycles[ch] = 0;
            end
        end
    endtask

    // Every input change happens here, on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        req_en = '0;
        collect_responses();
    endtask

    // Drives one request and updates the model in the same cycle
    task automatic send(input int ch, input mpf_pkg::t_mem_op op,
                        input logic [ADDR_BITS-1:0] addr, input logic [DATA_BITS-1:0] data);
        req_en[ch] = 1'b1;
        req_op[ch] = op;
        req_addr[ch] = addr;
        req_wdata[ch] = data;
        last_addr[ch] = addr;
        if (op == mpf_pkg::OP_WRITE)
        begin
            ref_mem[addr] = data;
            written[addr] = 1'b1;
        end
        else
        begin
            exp_q[ch].push_back(ref_mem[addr]);
            issued[ch]++;
        end
    endtask

    task automatic send_when_ready(input int ch, input mpf_pkg::t_mem_op op,
                                   input logic [ADDR_BITS-1:0] addr,
                                   input logic [DATA_BITS-1:0] data);
        int n = 0;
        next_cycle();
        while (!req_not_full[ch] && n < WAIT_LIMIT)
        begin
            next_cycle();
            n++;
        end
        if (req_not_full[ch])
        begin
            send(ch, op, addr, data);
        end
        else
        begin
            $display("Timeout: channel %0d request FIFO never accepted a request", ch);
            timeouts++;
        end
    endtask

    task automatic wait_drained(input int ch);
        int n = 0;
        while (exp_q[ch].size() != 0 && n < WAIT_LIMIT)
        begin
            next_cycle();
            n++;
        end
        if (exp_q[ch].size() != 0)
        begin
            $display("Timeout: channel %0d still waits for %0d reads", ch, exp_q[ch].size());
            timeouts++;
        end
    endtask

    // A trailing read comes back only after all earlier requests of its channel,
    // so both request FIFOs are empty once every queue has drained
    task automatic sync_channels();
        for (int ch = 0; ch < N_CH; ch++)
        begin
            send_when_ready(ch, mpf_pkg::OP_READ, last_addr[ch], '0);
        end
        for (int ch = 0; ch < N_CH; ch++)
        begin
            wait_drained(ch);
        end
    endtask

    // Both channels mix reads and writes inside their own half of the memory
    task automatic random_traffic(input int n_ops);
        logic [31:0] r;
        logic [ADDR_BITS-1:0] a;
        int done [N_CH] = '{default: 0};
        int cycles = 0;
        while ((done[0] < n_ops || done[1] < n_ops) && cycles < n_ops * 8)
        begin
            next_cycle();
            cycles++;
            for (int ch = 0; ch < N_CH; ch++)
            begin
                r = next_rand();
                if (done[ch] < n_ops && req_not_full[ch] && r[31:30] != 2'b00)
                begin
                    a = region_addr(ch, r);
                    // Unwritten words have no known contents, so such a read turns into a write
                    if (r[29] && written[a])
                    begin
                        send(ch, mpf_pkg::OP_READ, a, '0);
                    end
                    else
                    begin
                        send(ch, mpf_pkg::OP_WRITE, a, next_rand());
                    end
                    done[ch]++;
                end
            end
        end
        if (done[0] < n_ops || done[1] < n_ops)
        begin
            $display("Timeout: random traffic could not issue all of its requests");
            timeouts++;
        end
        sync_channels();
    endtask

    // Channel 0 writes a block, channel 1 reads it after channel 0 has drained
    task automatic shared_block();
        logic [ADDR_BITS-1:0] base = ADDR_BITS'(REGION / 2);
        for (int i = 0; i < 8; i++)
        begin
            send_when_ready(0, mpf_pkg::OP_WRITE, base + ADDR_BITS'(i), next_rand());
        end
        send_when_ready(0, mpf_pkg::OP_READ, base + ADDR_BITS'(7), '0);
        wait_drained(0);
        for (int i = 0; i < 8; i++)
        begin
            send_when_ready(1, mpf_pkg::OP_READ, base + ADDR_BITS'(i), '0);
        end
        wait_drained(1);
    endtask

    // Channel 1 stops taking responses, so its reads stall while a write still passes
    task automatic back_pressure();
        logic [ADDR_BITS-1:0] w_addr;
        int n = 0;
        drain_en[1] = 1'b0;
        // Three back to back reads push the response FIFO past its almost-full level
        for (int i = 0; i < 3; i++)
        begin
            send_when_ready(1, mpf_pkg::OP_READ, written_addr(1), '0);
        end
        while (!rsp_not_empty[1] && n < WAIT_LIMIT)
        begin
            next_cycle();
            n++;
        end
        if (!rsp_not_empty[1])
        begin
            $display("Timeout: channel 1 response FIFO never became not empty");
            timeouts++;
        end
        w_addr = written_addr(1);
        send_when_ready(1, mpf_pkg::OP_WRITE, w_addr, next_rand());
        // The write is dequeued one edge after it lands, leaving the request FIFO empty
        next_cycle();
        next_cycle();
        // Stalled reads now pile up one per cycle, so the flags follow the count
        for (int cnt = 0; cnt <= REQ_ENTRIES; cnt++)
        begin
            check_flag("req_almost_full", 1, req_almost_full[1], cnt >= REQ_ENTRIES - 1);
            check_flag("req_not_full", 1, req_not_full[1], cnt < REQ_ENTRIES);
            if (cnt < REQ_ENTRIES && req_not_full[1])
            begin
                send(1, mpf_pkg::OP_READ, written_addr(1), '0);
            end
            next_cycle();
        end
        drain_en[1] = 1'b1;
        wait_drained(1);
        // Reading the word back shows that the write went through under back-pressure
        send_when_ready(1, mpf_pkg::OP_READ, w_addr, '0);
        wait_drained(1);
    endtask

    // Both channels read as fast as their request FIFOs allow
    task automatic fairness(input int n_reads);
        int sent [N_CH] = '{default: 0};
        int cycles = 0;
        while ((sent[0] < n_reads || sent[1] < n_reads) && cycles < n_reads * 8)
        begin
            next_cycle();
            cycles++;
            for (int ch = 0; ch < N_CH; ch++)
            begin
                if (sent[ch] < n_reads && req_not_full[ch])
                begin
                    send(ch, mpf_pkg::OP_READ, written_addr(ch), '0);
                    sent[ch]++;
                end
            end
        end
        if (sent[0] < n_reads || sent[1] < n_reads)
        begin
            $display("Timeout: fairness traffic could not issue all of its reads");
            timeouts++;
        end
        for (int ch = 0; ch < N_CH; ch++)
        begin
            wait_drained(ch);
        end
    endtask

    initial
    begin
        int n;
        n = 0;
        seed = 32'he69c;
        req_en = '0;
        req_addr = '0;
        req_wdata = '0;
        rsp_deq = '0;
        drain_en = '1;
        written = '0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        for (int ch = 0; ch < N_CH; ch++)
        begin
            req_op[ch] = mpf_pkg::OP_READ;
            issued[ch] = 0;
            received[ch] = 0;
            idle_cycles[ch] = 0;
        end

        // Reset is released on a falling edge, so it is sampled on the rising one
        while (reset_n !== 1'b1 && n < 16)
        begin
            @(posedge clk);
            n++;
        end
        if (reset_n !== 1'b1)
        begin
            $display("Timeout: reset was never released");
            timeouts++;
        end
        next_cycle();
        for (int ch = 0; ch < N_CH; ch++)
        begin
            check_flag("req_not_full", ch, req_not_full[ch], 1'b1);
            check_flag("req_almost_full", ch, req_almost_full[ch], 1'b0);
            check_flag("rsp_not_empty", ch, rsp_not_empty[ch], 1'b0);
        end

        random_traffic(60);
        shared_block();
        back_pressure();
        fairness(40);

        for (int ch = 0; ch < N_CH; ch++)
        begin
            checks++;
            assert (received[ch] == issued[ch])
            else
            begin
                $display("ERR @%0t: channel %0d received %0d responses for %0d reads",
                         $time, ch, received[ch], issued[ch]);
                errors++;
            end
        end
        $display("Checks %0d, errors %0d, timeouts %0d, reads %0d and %0d",
                 checks, errors, timeouts, issued[0], issued[1]);
        if (errors == 0 && timeouts == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- sim.f
mpf_pkg.sv
mpf_fifo_lutram.sv
mpf_rr_arbiter.sv
mpf_shared_mem.sv
mpf_rsp_router.sv
mpf_mem_shim_top.sv
tb_clock_gen.sv
tb_mem_shim.sv
